/* flist.f */
common/conv_pkg.sv
conv_accum/partial_sum_buffer.sv
conv_accum/channel_accumulator.sv
rtl/bias_relu.sv
rtl/conv_channel_sum_top.sv
dv/conv_channel_sum_tb.sv

/* Makefile */
# Verilator flow for the channel sum stage
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR       ?= verilator
TOP             ?= conv_channel_sum_tb
FLIST           ?= flist.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --timing
PASS_PATTERN    ?= RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# Lint the whole tree with the testbench on top
lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FLIST) --top-module $(TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FLIST) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR)

# Pass or fail comes from the log
sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_PATTERN)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/conv_channel_sum_tb.sv */
module conv_channel_sum_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import conv_pkg::*;

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  localparam int IMAGE_SIZE     = 16;
  localparam int CHANNEL_NUM_IN = 4;
  localparam int ADD_LATENCY    = 2;
  localparam int NUM_ROWS       = 8;
  // Idle cycles allowed while the pipe drains
  localparam int DRAIN_TIMEOUT  = 200;

  // How a row builds its pixels
  typedef enum int {PIX_RANDOM, PIX_CONST, PIX_LARGE_POS, PIX_LARGE_NEG} pix_mode_t;
  // Idle cycles between pixels or not
  typedef enum int {GAP_NONE, GAP_RANDOM} gap_mode_t;
  // Expected result from the model or a fixed value
  typedef enum int {EXP_MODEL, EXP_ZERO, EXP_MAX} exp_mode_t;

  // DUT signals
  logic   clk;
  logic   reset;
  logic   valid_in;
  pixel_t pxl_in;
  pixel_t bias;
  logic   valid_out;
  pixel_t pxl_out;

  // Random stream
  int seed;

  // Marks a last channel pixel on valid_in
  logic in_last;

  // Monitor state
  int    cycle_cnt;
  int    out_count;
  int    exp_queue  [$];
  string name_queue [$];
  int    in_cycles  [$];

  // Running sums of the reference model per position
  int model_sum [IMAGE_SIZE];

  // Stimulus table
  string     row_name  [NUM_ROWS];
  pix_mode_t row_pix   [NUM_ROWS];
  int        row_const [NUM_ROWS];
  int        row_bias  [NUM_ROWS];
  gap_mode_t row_gap   [NUM_ROWS];
  exp_mode_t row_exp   [NUM_ROWS];

  conv_channel_sum_top #(
    .IMAGE_SIZE    (IMAGE_SIZE),
    .CHANNEL_NUM_IN(CHANNEL_NUM_IN),
    .ADD_LATENCY   (ADD_LATENCY)
  ) dut_i (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .bias     (bias),
    .valid_out(valid_out),
    .pxl_out  (pxl_out)
  );

  // 20 ns period
  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Failure handling and checks
  //////////////////////////////////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic signed [31:0] expected,
                             logic signed [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic set_row(int idx, string name, pix_mode_t pix, int const_val, int bias_val,
                         gap_mode_t gap, exp_mode_t exp_mode);
    row_name[idx]  = name;
    row_pix[idx]   = pix;
    row_const[idx] = const_val;
    row_bias[idx]  = bias_val;
    row_gap[idx]   = gap;
    row_exp[idx]   = exp_mode;
  endtask

  task automatic load_table();
    // Plain sums and a second frame straight after the first
    set_row(0, "random_zero_bias", PIX_RANDOM, 0, 0, GAP_NONE, EXP_MODEL);
    set_row(1, "random_back_to_back", PIX_RANDOM, 0, 0, GAP_NONE, EXP_MODEL);
    set_row(2, "constant_pos_bias", PIX_CONST, 1234, 500, GAP_NONE, EXP_MODEL);
    // ReLU cases
    set_row(3, "negative_bias_relu", PIX_CONST, 100, -1000, GAP_NONE, EXP_ZERO);
    set_row(4, "large_negative_relu", PIX_LARGE_NEG, 0, 300, GAP_NONE, EXP_ZERO);
    // Clip at the top of the pixel range
    set_row(5, "large_positive_clip", PIX_LARGE_POS, 0, 30000, GAP_NONE, EXP_MAX);
    // Idle cycles between pixels
    // Last row repeats row 2 with gaps
    set_row(6, "random_idle_gaps", PIX_RANDOM, 0, 77, GAP_RANDOM, EXP_MODEL);
    set_row(7, "constant_idle_gaps", PIX_CONST, 1234, 500, GAP_RANDOM, EXP_MODEL);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // ReLU below zero and clip above the pixel range
  function automatic int relu_clip(int total);
    if (total < 0) begin
      return 0;
    end else if (total > int'(PIXEL_MAX)) begin
      return int'(PIXEL_MAX);
    end
    return total;
  endfunction

  function automatic int expected_output(int row, int total);
    case (row_exp[row])
      EXP_ZERO: return 0;
      EXP_MAX:  return int'(PIXEL_MAX);
      default:  return relu_clip(total + row_bias[row]);
    endcase
  endfunction

  function automatic pixel_t make_pixel(pix_mode_t mode, int const_val);
    int r;
    r = $random(seed);
    case (mode)
      PIX_CONST:     return pixel_t'(const_val);
      // Four pixels of 20000 or more always reach the clip
      PIX_LARGE_POS: return pixel_t'(20000 + (r & 32'h1fff));
      PIX_LARGE_NEG: return pixel_t'(-20000 - (r & 32'h1fff));
      default:       return pixel_t'(r);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic idle_cycle();
    @(negedge clk);
    valid_in = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic send_pixel(pixel_t value, logic last, int expected, string name);
    @(negedge clk);
    valid_in = 1'b1;
    pxl_in   = value;
    in_last  = last;
    // Only last channel pixels produce an output
    if (last) begin
      exp_queue.push_back(expected);
      name_queue.push_back(name);
    end
  endtask

  // All channels of one frame
  task automatic run_frame(int row);
    pixel_t value;
    int     gap;
    int     expected;
    logic   last;
    bias = pixel_t'(row_bias[row]);
    for (int ch = 1; ch <= CHANNEL_NUM_IN; ch++) begin
      for (int pos = 0; pos < IMAGE_SIZE; pos++) begin
        if (row_gap[row] == GAP_RANDOM) begin
          gap = $random(seed) & 3;
          repeat (gap) idle_cycle();
        end
        value = make_pixel(row_pix[row], row_const[row]);
        // Channel 1 restarts the sum
        if (ch == 1) begin
          model_sum[pos] = int'(value);
        end else begin
          model_sum[pos] = model_sum[pos] + int'(value);
        end
        last     = (ch == CHANNEL_NUM_IN);
        expected = expected_output(row, model_sum[pos]);
        send_pixel(value, last, expected, $sformatf("%s pos %0d", row_name[row], pos));
      end
    end
  endtask

  // Idle until the output count reaches the target
  task automatic wait_outputs(int target);
    int waited;
    waited = 0;
    while (out_count < target) begin
      if (waited > DRAIN_TIMEOUT) begin
        abort_run($sformatf("Timeout waiting for output pixels, %0d of %0d seen",
                            out_count, target));
      end else begin
        idle_cycle();
        waited = waited + 1;
      end
    end
    // Room for a stray extra output to reach the monitor
    repeat (ADD_LATENCY + 2) idle_cycle();
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  // Checks value and latency of every output
  always @(posedge clk) begin : output_monitor
    int    expected;
    int    start;
    string name;
    cycle_cnt = cycle_cnt + 1;
    if (!reset) begin
      if (valid_in && in_last) begin
        in_cycles.push_back(cycle_cnt);
      end
      if (valid_out) begin
        if (exp_queue.size() == 0) begin
          abort_run("valid_out went high while no output pixel was expected");
        end else begin
          expected = exp_queue.pop_front();
          name     = name_queue.pop_front();
          start    = in_cycles.pop_front();
          check_value(name, expected, 32'(pxl_out));
          check_value({name, " latency"}, ADD_LATENCY + 2, cycle_cnt - start);
          out_count = out_count + 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main_sequence
    int frames_sent;
    clk       = 1'b0;
    reset     = 1'b1;
    valid_in  = 1'b0;
    pxl_in    = '0;
    bias      = '0;
    in_last   = 1'b0;
    seed      = 32'hbdadb193;
    cycle_cnt = 0;
    out_count = 0;
    frames_sent = 0;
    load_table();

    // Reset for 8 cycles
    repeat (8) @(negedge clk);
    reset = 1'b0;
    check_value("valid_out_after_reset", 0, 32'(valid_out));

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_frame(r);
      frames_sent = frames_sent + 1;
      // Drain before the bias changes
      if (r == NUM_ROWS - 1 || row_bias[r + 1] != row_bias[r]) begin
        wait_outputs(frames_sent * IMAGE_SIZE);
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* rtl/conv_channel_sum_top.sv */
//////////////////////////////////////////////////
// Channel sum stage of a convolution layer
//////////////////////////////////////////////////

module conv_channel_sum_top #(
  parameter int IMAGE_SIZE     = 64 * 64,
  parameter int CHANNEL_NUM_IN = 64,
  parameter int ADD_LATENCY    = 2
) (
  input  logic             clk,
  input  logic             reset,
  // Convolver output stream
  input  logic             valid_in,
  input  conv_pkg::pixel_t pxl_in,
  // Output channel bias
  input  conv_pkg::pixel_t bias,
  // Activated pixels
  output logic             valid_out,
  output conv_pkg::pixel_t pxl_out
);

  import conv_pkg::*;

  // Accumulator to output stage
  logic sum_valid;
  sum_t sum_out;

  // Sums over all input channels
  channel_accumulator #(
    .IMAGE_SIZE    (IMAGE_SIZE),
    .CHANNEL_NUM_IN(CHANNEL_NUM_IN),
    .ADD_LATENCY   (ADD_LATENCY)
  ) accum_i (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .sum_valid(sum_valid),
    .sum_out  (sum_out)
  );

  // One cycle bias and activation
  bias_relu relu_i (
    .clk      (clk),
    .reset    (reset),
    .sum_valid(sum_valid),
    .sum_in   (sum_out),
    .bias     (bias),
    .valid_out(valid_out),
    .pxl_out  (pxl_out)
  );

endmodule

/* rtl/bias_relu.sv */
//////////////////////////////////////////////////
// Bias, ReLU and clip output stage
//////////////////////////////////////////////////

module bias_relu (
  input  logic             clk,
  input  logic             reset,
  // Finished channel sums
  input  logic             sum_valid,
  input  conv_pkg::sum_t   sum_in,
  // Bias level, sampled with each sum
  input  conv_pkg::pixel_t bias,
  // Output pixels
  output logic             valid_out,
  output conv_pkg::pixel_t pxl_out
);

  import conv_pkg::*;

  // One extra bit so the bias add cannot overflow
  localparam int WIDE_WIDTH = SUM_WIDTH + 1;

  logic signed [WIDE_WIDTH-1:0] biased;
  pixel_t                       clipped;

  // Both operands sign-extended
  assign biased = {sum_in[SUM_WIDTH-1], sum_in}
                + {{(WIDE_WIDTH - PIXEL_WIDTH){bias[PIXEL_WIDTH-1]}}, bias};

  // ReLU below, clip above
  always_comb begin
    if (biased < 0) begin
      clipped = '0;
    end else if (biased > PIXEL_MAX) begin
      clipped = PIXEL_MAX;
    end else begin
      clipped = biased[PIXEL_WIDTH-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= sum_valid;
    end
  end

  // Result loads only with a valid sum
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      pxl_out <= clipped;
    end
  end

endmodule

/* conv_accum/channel_accumulator.sv */
//////////////////////////////////////////////////
// Input channel accumulator
//////////////////////////////////////////////////

module channel_accumulator #(
  parameter int IMAGE_SIZE     = 64 * 64,
  parameter int CHANNEL_NUM_IN = 64,
  parameter int ADD_LATENCY    = 2
) (
  input  logic             clk,
  input  logic             reset,
  // Pixel stream, one channel image after another
  input  logic             valid_in,
  input  conv_pkg::pixel_t pxl_in,
  // Finished sums, last channel only
  output logic             sum_valid,
  output conv_pkg::sum_t   sum_out
);

  import conv_pkg::*;

  localparam int ADDR_WIDTH = $clog2(IMAGE_SIZE);
  localparam int CH_WIDTH   = $clog2(CHANNEL_NUM_IN + 1);

  //////////////////////////////////////////////////
  // Pixel and channel counters
  //////////////////////////////////////////////////

  logic [ADDR_WIDTH-1:0] pxl_cnt;
  logic [CH_WIDTH-1:0]   ch_cnt;
  logic                  pxl_wrap;
  logic                  ch_first;
  logic                  ch_last;

  assign pxl_wrap = (pxl_cnt == ADDR_WIDTH'(IMAGE_SIZE - 1));
  assign ch_first = (ch_cnt == CH_WIDTH'(1));
  assign ch_last  = (ch_cnt == CH_WIDTH'(CHANNEL_NUM_IN));

  // Both counters move on valid pixels only
  always_ff @(posedge clk) begin
    if (reset) begin
      pxl_cnt <= '0;
      ch_cnt  <= CH_WIDTH'(1);
    end else if (valid_in) begin
      if (pxl_wrap) begin
        pxl_cnt <= '0;
        // Channel steps at the end of each image
        if (ch_last) begin
          ch_cnt <= CH_WIDTH'(1);
        end else begin
          ch_cnt <= ch_cnt + CH_WIDTH'(1);
        end
      end else begin
        pxl_cnt <= pxl_cnt + ADDR_WIDTH'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // Partial sum buffer
  //////////////////////////////////////////////////

  logic                  rd_en;
  sum_t                  rd_data;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  sum_t                  wr_data;

  // Read at the current position on every valid pixel
  assign rd_en = valid_in;

  partial_sum_buffer #(
    .IMAGE_SIZE(IMAGE_SIZE)
  ) buffer_i (
    .clk    (clk),
    .rd_en  (rd_en),
    .rd_addr(pxl_cnt),
    .rd_data(rd_data),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

  //////////////////////////////////////////////////
  // Alignment stage
  //////////////////////////////////////////////////

  // Pixel waits one cycle for the buffer read
  logic                  align_valid;
  logic                  align_first;
  logic                  align_last;
  logic [ADDR_WIDTH-1:0] align_addr;
  sum_t                  align_pxl;

  always_ff @(posedge clk) begin
    if (reset) begin
      align_valid <= 1'b0;
    end else begin
      align_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    align_first <= ch_first;
    align_last  <= ch_last;
    align_addr  <= pxl_cnt;
    // Sign extension to the sum width
    align_pxl   <= {{(SUM_WIDTH - PIXEL_WIDTH){pxl_in[PIXEL_WIDTH-1]}}, pxl_in};
  end

  //////////////////////////////////////////////////
  // Adder pipeline
  //////////////////////////////////////////////////

  sum_t                  addend;
  sum_t                  add_result;
  sum_t                  pipe_sum  [ADD_LATENCY];
  logic [ADDR_WIDTH-1:0] pipe_addr [ADD_LATENCY];
  logic [ADD_LATENCY-1:0] pipe_last;
  logic [ADD_LATENCY-1:0] pipe_valid;

  // Channel 1 starts from zero
  // Stale entries from the previous frame never reach the adder
  assign addend     = align_first ? '0 : rd_data;
  assign add_result = align_pxl + addend;

  // Valid bits of the stages
  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid[0] <= align_valid;
      for (int i = 1; i < ADD_LATENCY; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
    end
  end

  // Sum, position and last channel flag per stage
  always_ff @(posedge clk) begin
    pipe_sum[0]  <= add_result;
    pipe_addr[0] <= align_addr;
    pipe_last[0] <= align_last;
    for (int i = 1; i < ADD_LATENCY; i++) begin
      pipe_sum[i]  <= pipe_sum[i-1];
      pipe_addr[i] <= pipe_addr[i-1];
      pipe_last[i] <= pipe_last[i-1];
    end
  end

  //////////////////////////////////////////////////
  // Write back and output
  //////////////////////////////////////////////////

  // Every sum goes back to its position
  assign wr_en   = pipe_valid[ADD_LATENCY-1];
  assign wr_addr = pipe_addr[ADD_LATENCY-1];
  assign wr_data = pipe_sum[ADD_LATENCY-1];

  // Last channel sums also leave the stage
  assign sum_valid = pipe_valid[ADD_LATENCY-1] & pipe_last[ADD_LATENCY-1];
  assign sum_out   = pipe_sum[ADD_LATENCY-1];

endmodule

/* conv_accum/partial_sum_buffer.sv */
//////////////////////////////////////////////////
// Partial sum storage, one entry per position
//////////////////////////////////////////////////

module partial_sum_buffer #(
  parameter int IMAGE_SIZE = 64 * 64
) (
  input  logic                          clk,
  // Read port, data one cycle after rd_en
  input  logic                          rd_en,
  input  logic [$clog2(IMAGE_SIZE)-1:0] rd_addr,
  output conv_pkg::sum_t                rd_data,
  // Write port from the end of the adder pipe
  input  logic                          wr_en,
  input  logic [$clog2(IMAGE_SIZE)-1:0] wr_addr,
  input  conv_pkg::sum_t                wr_data
);

  import conv_pkg::*;

  // Storage array
  // Simple dual port block RAM
  sum_t mem [IMAGE_SIZE];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Registered read
  // Same-address write in the same cycle returns the old entry
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* common/conv_pkg.sv */
//////////////////////////////////////////////////
// Types and widths for the channel sum path
//////////////////////////////////////////////////

package conv_pkg;

  // Pixel width at the input and at the output
  localparam int PIXEL_WIDTH = 16;

  // Partial sum width
  // 8 bits above the pixel width cover 256 channels of full-scale pixels
  localparam int SUM_WIDTH = 24;

  // Signed pixel as delivered by the convolvers
  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;

  // Signed running sum over input channels
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // Largest positive pixel value
  // Upper clip limit after bias and ReLU
  localparam pixel_t PIXEL_MAX = pixel_t'((1 << (PIXEL_WIDTH - 1)) - 1);

endpackage
